/* axil_xbar.f */
logic/axil_xbar_pkg.sv
logic/xbar_arbiter.sv
logic/xbar_decoder.sv
logic/xbar_ctrl.sv
logic/xbar_wr_route.sv
logic/xbar_rd_route.sv
logic/axil_xbar.sv
tb/tb_clock.sv
tb/axil_xbar_assert.sv
tb/tb_axil_xbar.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axil_xbar \
    -f axil_xbar.f \
    -Mdir obj_dir -o sim_axil_xbar
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_axil_xbar
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

/* tb/tb_axil_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_xbar import axil_xbar_pkg::*;;

    localparam int N_MST   = 2;
    localparam int N_SLV   = 3;
    localparam int TIMEOUT = 200;
    localparam int CH_AW   = 0;
    localparam int CH_W    = 1;
    localparam int CH_B    = 2;
    localparam int CH_AR   = 3;
    localparam int CH_R    = 4;
    localparam logic [ADDR_WIDTH-1:0] MISS_ADDR = 32'h1000_0040;

    logic                  clk_i;
    logic                  rstn_i;
    axil_req_t [N_MST-1:0] mst_req;
    axil_rsp_t [N_MST-1:0] mst_rsp;
    axil_req_t [N_SLV-1:0] slv_req;
    axil_rsp_t [N_SLV-1:0] slv_rsp = '0;

    integer                seed = 32'h01db_2937;
    logic [DATA_WIDTH-1:0] mem [N_SLV][64];
    logic [ADDR_WIDTH-1:0] last_aw [N_SLV];
    logic [ADDR_WIDTH-1:0] last_ar [N_SLV];
    time                   done_t [N_MST];

    tb_clock clk_gen_i (.clk_o(clk_i));

    axil_xbar #(
        .N_MST (N_MST),
        .N_SLV (N_SLV),
        .SLV_LO({32'h43c2_0000, 32'h43c1_0000, 32'h43c0_0000}),
        .SLV_HI({32'h43c2_ffff, 32'h43c1_ffff, 32'h43c0_ffff})
    ) dut_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .mst_req_i(mst_req),
        .mst_rsp_o(mst_rsp),
        .slv_req_o(slv_req),
        .slv_rsp_i(slv_rsp)
    );

    // ========================================================================
    // subordinate memory models with randomly delayed readies
    // ========================================================================

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slv_rsp <= '0;
            for (int s = 0; s < N_SLV; s++) begin
                last_aw[s] <= '0;
                last_ar[s] <= '0;
            end
        end else begin
            for (int s = 0; s < N_SLV; s++) begin
                if (slv_req[s].awvalid && slv_rsp[s].awready) begin
                    slv_rsp[s].awready <= 1'b0;
                    last_aw[s]         <= slv_req[s].awaddr;
                end else if (slv_req[s].awvalid && !slv_rsp[s].bvalid) begin
                    slv_rsp[s].awready <= (($random(seed) & 3) == 0);
                end
                if (slv_req[s].wvalid && slv_rsp[s].wready) begin
                    slv_rsp[s].wready <= 1'b0;
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (slv_req[s].wstrb[b]) begin
                            mem[s][last_aw[s][7:2]][8*b +: 8] <= slv_req[s].wdata[8*b +: 8];
                        end
                    end
                    slv_rsp[s].bvalid <= 1'b1;
                    slv_rsp[s].bresp  <= RESP_OKAY;
                end else if (slv_req[s].wvalid) begin
                    slv_rsp[s].wready <= (($random(seed) & 3) == 0);
                end
                if (slv_rsp[s].bvalid && slv_req[s].bready) begin
                    slv_rsp[s].bvalid <= 1'b0;
                end
                if (slv_req[s].arvalid && slv_rsp[s].arready) begin
                    slv_rsp[s].arready <= 1'b0;
                    last_ar[s]         <= slv_req[s].araddr;
                    slv_rsp[s].rdata   <= mem[s][slv_req[s].araddr[7:2]];
                    slv_rsp[s].rresp   <= RESP_OKAY;
                    slv_rsp[s].rvalid  <= 1'b1;
                end else if (slv_req[s].arvalid && !slv_rsp[s].rvalid) begin
                    slv_rsp[s].arready <= (($random(seed) & 3) == 0);
                end
                if (slv_rsp[s].rvalid && slv_req[s].rready) begin
                    slv_rsp[s].rvalid <= 1'b0;
                end
            end
        end
    end

    // ========================================================================
    // failure reporting and compare tasks
    // ========================================================================

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_resp(input string test, input resp_e exp, input resp_e act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s expected %s actual %s",
                                  test, exp.name(), act.name()));
        end
    endtask

    task automatic check_data(input string test, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", test, exp, act));
        end
    endtask

    task automatic check_addr(input string test, input logic [ADDR_WIDTH-1:0] exp,
                              input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", test, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s expected %0b actual %0b", test, exp, act));
        end
    endtask

    // ========================================================================
    // manager side
    // ========================================================================

    function automatic logic chan_bit(input int m, input int ch);
        case (ch)
            CH_AW:   return mst_rsp[m].awready;
            CH_W:    return mst_rsp[m].wready;
            CH_B:    return mst_rsp[m].bvalid;
            CH_AR:   return mst_rsp[m].arready;
            default: return mst_rsp[m].rvalid;
        endcase
    endfunction

    task automatic wait_chan(input int m, input int ch, input string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(posedge clk_i);
            seen = chan_bit(m, ch);
            n++;
        end
        if (!seen) begin
            report_fail($sformatf("timeout waiting for %s on manager %0d", what, m));
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] pattern(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] slv_addr(input int s, input int word);
        return 32'h43c0_0000 + (ADDR_WIDTH'(s) << 16) + (ADDR_WIDTH'(word) << 2);
    endfunction

    task automatic do_write(input int m, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data, input int bp,
                            output resp_e resp);
        @(posedge clk_i);
        mst_req[m].awaddr  <= addr;
        mst_req[m].awprot  <= 3'b000;
        mst_req[m].awvalid <= 1'b1;
        mst_req[m].wdata   <= data;
        mst_req[m].wstrb   <= '1;
        mst_req[m].wvalid  <= 1'b1;
        wait_chan(m, CH_AW, "awready");
        mst_req[m].awvalid <= 1'b0;
        wait_chan(m, CH_W, "wready");
        mst_req[m].wvalid <= 1'b0;
        wait_chan(m, CH_B, "bvalid");
        resp = mst_rsp[m].bresp;
        // response must hold while bready stays low
        repeat (bp) begin
            @(posedge clk_i);
            check_flag("b hold valid", 1'b1, mst_rsp[m].bvalid);
            check_resp("b hold resp", resp, mst_rsp[m].bresp);
        end
        mst_req[m].bready <= 1'b1;
        wait_chan(m, CH_B, "bvalid");
        mst_req[m].bready <= 1'b0;
        done_t[m] = $time;
    endtask

    task automatic do_read(input int m, input logic [ADDR_WIDTH-1:0] addr, input int bp,
                           output logic [DATA_WIDTH-1:0] data, output resp_e resp);
        @(posedge clk_i);
        mst_req[m].araddr  <= addr;
        mst_req[m].arprot  <= 3'b000;
        mst_req[m].arvalid <= 1'b1;
        wait_chan(m, CH_AR, "arready");
        mst_req[m].arvalid <= 1'b0;
        wait_chan(m, CH_R, "rvalid");
        resp = mst_rsp[m].rresp;
        data = mst_rsp[m].rdata;
        repeat (bp) begin
            @(posedge clk_i);
            check_flag("r hold valid", 1'b1, mst_rsp[m].rvalid);
            check_resp("r hold resp", resp, mst_rsp[m].rresp);
            check_data("r hold data", data, mst_rsp[m].rdata);
        end
        mst_req[m].rready <= 1'b1;
        wait_chan(m, CH_R, "rvalid");
        mst_req[m].rready <= 1'b0;
    endtask

    task automatic apply_reset();
        rstn_i  <= 1'b0;
        mst_req <= '0;
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================

    task automatic idle_after_reset();
        for (int m = 0; m < N_MST; m++) begin
            check_flag("reset mst", 1'b0, mst_rsp[m].awready | mst_rsp[m].wready |
                       mst_rsp[m].bvalid | mst_rsp[m].arready | mst_rsp[m].rvalid);
        end
        for (int s = 0; s < N_SLV; s++) begin
            check_flag("reset slv", 1'b0, slv_req[s].awvalid | slv_req[s].wvalid |
                       slv_req[s].bready | slv_req[s].arvalid | slv_req[s].rready);
        end
    endtask

    task automatic each_slv_write_read();
        resp_e                 resp;
        logic [DATA_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] addr;
        for (int s = 0; s < N_SLV; s++) begin
            addr = slv_addr(s, 16);
            do_write(0, addr, pattern(addr), 0, resp);
            check_resp("slave write resp", RESP_OKAY, resp);
            check_addr("slave write addr", addr, last_aw[s]);
            do_read(0, addr, 0, data, resp);
            check_resp("slave read resp", RESP_OKAY, resp);
            check_data("slave read data", pattern(addr), data);
            check_addr("slave read addr", addr, last_ar[s]);
        end
    endtask

    task automatic decode_miss();
        resp_e                 resp;
        logic [DATA_WIDTH-1:0] data;
        do_write(0, MISS_ADDR, 32'hdead_beef, 0, resp);
        check_resp("miss write resp", RESP_DECERR, resp);
        do_read(1, MISS_ADDR, 0, data, resp);
        check_resp("miss read resp", RESP_DECERR, resp);
        check_data("miss read data", '0, data);
    endtask

    // lone write from manager 0 moves the pointer to manager 1
    task automatic round_robin_order();
        resp_e r0;
        resp_e r1;
        apply_reset();
        fork
            do_write(0, slv_addr(0, 20), pattern(slv_addr(0, 20)), 0, r0);
            do_write(1, slv_addr(1, 20), pattern(slv_addr(1, 20)), 0, r1);
        join
        check_resp("rr first resp0", RESP_OKAY, r0);
        check_resp("rr first resp1", RESP_OKAY, r1);
        check_flag("rr first order", 1'b1, done_t[0] < done_t[1]);
        do_write(0, slv_addr(2, 20), pattern(slv_addr(2, 20)), 0, r0);
        fork
            do_write(0, slv_addr(0, 21), pattern(slv_addr(0, 21)), 0, r0);
            do_write(1, slv_addr(1, 21), pattern(slv_addr(1, 21)), 0, r1);
        join
        check_resp("rr second resp0", RESP_OKAY, r0);
        check_resp("rr second resp1", RESP_OKAY, r1);
        check_flag("rr second order", 1'b1, done_t[1] < done_t[0]);
    endtask

    task automatic back_pressure_hold();
        resp_e                 resp;
        logic [DATA_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] addr;
        addr = slv_addr(2, 33);
        do_write(1, addr, pattern(addr), ($random(seed) & 7) + 2, resp);
        check_resp("bp write resp", RESP_OKAY, resp);
        do_read(1, addr, ($random(seed) & 7) + 2, data, resp);
        check_resp("bp read resp", RESP_OKAY, resp);
        check_data("bp read data", pattern(addr), data);
    endtask

    task automatic write_read_overlap();
        resp_e                 wr_resp;
        resp_e                 rd_resp;
        logic [DATA_WIDTH-1:0] data;
        fork
            do_write(0, slv_addr(0, 40), pattern(slv_addr(0, 40)), 0, wr_resp);
            do_read(1, slv_addr(1, 20), 0, data, rd_resp);
        join
        check_resp("overlap write resp", RESP_OKAY, wr_resp);
        check_resp("overlap read resp", RESP_OKAY, rd_resp);
        check_data("overlap read data", pattern(slv_addr(1, 20)), data);
        check_addr("overlap write addr", slv_addr(0, 40), last_aw[0]);
        check_addr("overlap read addr", slv_addr(1, 20), last_ar[1]);
    endtask

    initial begin
        rstn_i  = 1'b0;
        mst_req = '0;
        apply_reset();
        idle_after_reset();
        each_slv_write_read();
        decode_miss();
        round_robin_order();
        back_pressure_hold();
        write_read_overlap();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/axil_xbar_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_xbar_assert import axil_xbar_pkg::*; #(
    parameter int N_MST = 2,
    parameter int N_SLV = 3
) (
    input wire logic                  clk_i,
    input wire logic                  rstn_i,
    input wire axil_req_t [N_MST-1:0] mst_req_i,
    input wire axil_rsp_t [N_MST-1:0] mst_rsp_i,
    input wire axil_req_t [N_SLV-1:0] slv_req_i,
    input wire route_t                wr_route_i,
    input wire route_t                rd_route_i
);

    logic [N_SLV-1:0] aw_v;
    logic [N_SLV-1:0] w_v;
    logic [N_SLV-1:0] ar_v;

    for (genvar s = 0; s < N_SLV; s++) begin : g_slv
        assign aw_v[s] = slv_req_i[s].awvalid;
        assign w_v[s]  = slv_req_i[s].wvalid;
        assign ar_v[s] = slv_req_i[s].arvalid;
    end

    a_one_slv_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(aw_v) && $onehot0(ar_v))
        else $error("more than one subordinate address valid");

    // a miss never reaches a subordinate
    a_miss_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wr_route_i.hit || (aw_v == '0 && w_v == '0)) &&
        (rd_route_i.hit || ar_v == '0))
        else $error("subordinate valid on a decode miss");

    for (genvar m = 0; m < N_MST; m++) begin : g_mst
        a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
            (mst_rsp_i[m].bvalid && !mst_req_i[m].bready) |=> mst_rsp_i[m].bvalid)
            else $error("bvalid dropped before bready");
    end

endmodule

bind axil_xbar axil_xbar_assert #(
    .N_MST(N_MST),
    .N_SLV(N_SLV)
) assert_i (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .mst_req_i (mst_req_i),
    .mst_rsp_i (mst_rsp_o),
    .slv_req_i (slv_req_o),
    .wr_route_i(wr_route_q),
    .rd_route_i(rd_route_q)
);

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter realtime HALF_PERIOD = 4.0
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* logic/axil_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_xbar import axil_xbar_pkg::*; #(
    parameter int N_MST = 2,
    parameter int N_SLV = 3,
    parameter logic [N_SLV-1:0][ADDR_WIDTH-1:0] SLV_LO = {
        32'h43c2_0000,
        32'h43c1_0000,
        32'h43c0_0000
    },
    parameter logic [N_SLV-1:0][ADDR_WIDTH-1:0] SLV_HI = {
        32'h43c2_ffff,
        32'h43c1_ffff,
        32'h43c0_ffff
    }
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  axil_req_t [N_MST-1:0]  mst_req_i,
    output axil_rsp_t [N_MST-1:0]  mst_rsp_o,
    output axil_req_t [N_SLV-1:0]  slv_req_o,
    input  axil_rsp_t [N_SLV-1:0]  slv_rsp_i
);

    logic [N_MST-1:0]                 wr_req;
    logic [N_MST-1:0]                 rd_req;
    logic [N_MST-1:0][ADDR_WIDTH-1:0] wr_addr;
    logic [N_MST-1:0][ADDR_WIDTH-1:0] rd_addr;
    logic [N_MST-1:0]                 wr_grant;
    logic [N_MST-1:0]                 rd_grant;
    route_t                           wr_route;
    route_t                           rd_route;
    route_t                           wr_route_q;
    route_t                           rd_route_q;
    wr_state_e                        wr_state;
    rd_state_e                        rd_state;
    logic                             wr_step;
    logic                             rd_step;
    logic                             wr_ack;
    logic                             rd_ack;
    axil_rsp_t [N_MST-1:0]            wr_mst_rsp;
    axil_rsp_t [N_MST-1:0]            rd_mst_rsp;
    axil_req_t [N_SLV-1:0]            wr_slv_req;
    axil_req_t [N_SLV-1:0]            rd_slv_req;

    for (genvar i = 0; i < N_MST; i++) begin : g_mst
        assign wr_req[i]  = mst_req_i[i].awvalid;
        assign rd_req[i]  = mst_req_i[i].arvalid;
        assign wr_addr[i] = mst_req_i[i].awaddr;
        assign rd_addr[i] = mst_req_i[i].araddr;

        assign mst_rsp_o[i] = '{
            awready: wr_mst_rsp[i].awready,
            wready:  wr_mst_rsp[i].wready,
            bresp:   wr_mst_rsp[i].bresp,
            bvalid:  wr_mst_rsp[i].bvalid,
            arready: rd_mst_rsp[i].arready,
            rdata:   rd_mst_rsp[i].rdata,
            rresp:   rd_mst_rsp[i].rresp,
            rvalid:  rd_mst_rsp[i].rvalid
        };
    end

    for (genvar i = 0; i < N_SLV; i++) begin : g_slv
        assign slv_req_o[i] = '{
            awaddr:  wr_slv_req[i].awaddr,
            awprot:  wr_slv_req[i].awprot,
            awvalid: wr_slv_req[i].awvalid,
            wdata:   wr_slv_req[i].wdata,
            wstrb:   wr_slv_req[i].wstrb,
            wvalid:  wr_slv_req[i].wvalid,
            bready:  wr_slv_req[i].bready,
            araddr:  rd_slv_req[i].araddr,
            arprot:  rd_slv_req[i].arprot,
            arvalid: rd_slv_req[i].arvalid,
            rready:  rd_slv_req[i].rready
        };
    end

    // ========================================================================
    // arbitration and decode
    // ========================================================================

    xbar_arbiter #(
        .N_MST(N_MST)
    ) wr_arb_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (wr_req),
        .ack_i  (wr_ack),
        .grant_o(wr_grant)
    );

    xbar_arbiter #(
        .N_MST(N_MST)
    ) rd_arb_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (rd_req),
        .ack_i  (rd_ack),
        .grant_o(rd_grant)
    );

    xbar_decoder #(
        .N_MST (N_MST),
        .N_SLV (N_SLV),
        .SLV_LO(SLV_LO),
        .SLV_HI(SLV_HI)
    ) wr_dec_i (
        .grant_i(wr_grant),
        .addr_i (wr_addr),
        .route_o(wr_route)
    );

    xbar_decoder #(
        .N_MST (N_MST),
        .N_SLV (N_SLV),
        .SLV_LO(SLV_LO),
        .SLV_HI(SLV_HI)
    ) rd_dec_i (
        .grant_i(rd_grant),
        .addr_i (rd_addr),
        .route_o(rd_route)
    );

    // ========================================================================
    // control and channel steering
    // ========================================================================

    xbar_ctrl #(
        .N_MST(N_MST)
    ) ctrl_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_grant_i(wr_grant),
        .rd_grant_i(rd_grant),
        .wr_route_i(wr_route),
        .rd_route_i(rd_route),
        .wr_step_i (wr_step),
        .rd_step_i (rd_step),
        .wr_state_o(wr_state),
        .rd_state_o(rd_state),
        .wr_route_o(wr_route_q),
        .rd_route_o(rd_route_q),
        .wr_ack_o  (wr_ack),
        .rd_ack_o  (rd_ack)
    );

    xbar_wr_route #(
        .N_MST(N_MST),
        .N_SLV(N_SLV)
    ) wr_route_i (
        .state_i  (wr_state),
        .route_i  (wr_route_q),
        .mst_req_i(mst_req_i),
        .slv_rsp_i(slv_rsp_i),
        .mst_rsp_o(wr_mst_rsp),
        .slv_req_o(wr_slv_req),
        .step_o   (wr_step)
    );

    xbar_rd_route #(
        .N_MST(N_MST),
        .N_SLV(N_SLV)
    ) rd_route_i (
        .state_i  (rd_state),
        .route_i  (rd_route_q),
        .mst_req_i(mst_req_i),
        .slv_rsp_i(slv_rsp_i),
        .mst_rsp_o(rd_mst_rsp),
        .slv_req_o(rd_slv_req),
        .step_o   (rd_step)
    );

endmodule

`default_nettype wire

/* logic/xbar_rd_route.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_rd_route import axil_xbar_pkg::*; #(
    parameter int N_MST = 2,
    parameter int N_SLV = 3
) (
    input  rd_state_e             state_i,
    input  route_t                route_i,
    input  axil_req_t [N_MST-1:0] mst_req_i,
    input  axil_rsp_t [N_SLV-1:0] slv_rsp_i,
    output axil_rsp_t [N_MST-1:0] mst_rsp_o,
    output axil_req_t [N_SLV-1:0] slv_req_o,
    output logic                  step_o
);

    axil_req_t mst_req;
    axil_rsp_t slv_rsp;

    assign mst_req = mst_req_i[route_i.mst_idx];
    assign slv_rsp = slv_rsp_i[route_i.slv_idx];

    always_comb begin
        mst_rsp_o = '0;
        slv_req_o = '0;
        step_o    = 1'b0;
        case (state_i)
            RD_ADDR: begin
                if (route_i.hit) begin
                    slv_req_o[route_i.slv_idx].araddr  = mst_req.araddr;
                    slv_req_o[route_i.slv_idx].arprot  = mst_req.arprot;
                    slv_req_o[route_i.slv_idx].arvalid = mst_req.arvalid;
                    mst_rsp_o[route_i.mst_idx].arready = slv_rsp.arready;
                    step_o = mst_req.arvalid && slv_rsp.arready;
                end else begin
                    mst_rsp_o[route_i.mst_idx].arready = 1'b1;
                    step_o = mst_req.arvalid;
                end
            end
            RD_DATA: begin
                if (route_i.hit) begin
                    slv_req_o[route_i.slv_idx].rready = mst_req.rready;
                    mst_rsp_o[route_i.mst_idx].rvalid = slv_rsp.rvalid;
                    mst_rsp_o[route_i.mst_idx].rresp  = slv_rsp.rresp;
                    mst_rsp_o[route_i.mst_idx].rdata  = slv_rsp.rdata;
                    step_o = slv_rsp.rvalid && mst_req.rready;
                end else begin
                    // decode error, rdata stays zero
                    mst_rsp_o[route_i.mst_idx].rvalid = 1'b1;
                    mst_rsp_o[route_i.mst_idx].rresp  = RESP_DECERR;
                    step_o = mst_req.rready;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/xbar_wr_route.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_wr_route import axil_xbar_pkg::*; #(
    parameter int N_MST = 2,
    parameter int N_SLV = 3
) (
    input  wr_state_e             state_i,
    input  route_t                route_i,
    input  axil_req_t [N_MST-1:0] mst_req_i,
    input  axil_rsp_t [N_SLV-1:0] slv_rsp_i,
    output axil_rsp_t [N_MST-1:0] mst_rsp_o,
    output axil_req_t [N_SLV-1:0] slv_req_o,
    output logic                  step_o
);

    axil_req_t mst_req;
    axil_rsp_t slv_rsp;

    assign mst_req = mst_req_i[route_i.mst_idx];
    assign slv_rsp = slv_rsp_i[route_i.slv_idx];

    // only the lane pair of the current route is live
    always_comb begin
        mst_rsp_o = '0;
        slv_req_o = '0;
        step_o    = 1'b0;
        case (state_i)
            WR_ADDR: begin
                if (route_i.hit) begin
                    slv_req_o[route_i.slv_idx].awaddr  = mst_req.awaddr;
                    slv_req_o[route_i.slv_idx].awprot  = mst_req.awprot;
                    slv_req_o[route_i.slv_idx].awvalid = mst_req.awvalid;
                    mst_rsp_o[route_i.mst_idx].awready = slv_rsp.awready;
                    step_o = mst_req.awvalid && slv_rsp.awready;
                end else begin
                    mst_rsp_o[route_i.mst_idx].awready = 1'b1;
                    step_o = mst_req.awvalid;
                end
            end
            WR_DATA: begin
                if (route_i.hit) begin
                    slv_req_o[route_i.slv_idx].wdata  = mst_req.wdata;
                    slv_req_o[route_i.slv_idx].wstrb  = mst_req.wstrb;
                    slv_req_o[route_i.slv_idx].wvalid = mst_req.wvalid;
                    mst_rsp_o[route_i.mst_idx].wready = slv_rsp.wready;
                    step_o = mst_req.wvalid && slv_rsp.wready;
                end else begin
                    // miss, data is dropped
                    mst_rsp_o[route_i.mst_idx].wready = 1'b1;
                    step_o = mst_req.wvalid;
                end
            end
            WR_RESP: begin
                if (route_i.hit) begin
                    slv_req_o[route_i.slv_idx].bready = mst_req.bready;
                    mst_rsp_o[route_i.mst_idx].bvalid = slv_rsp.bvalid;
                    mst_rsp_o[route_i.mst_idx].bresp  = slv_rsp.bresp;
                    step_o = slv_rsp.bvalid && mst_req.bready;
                end else begin
                    mst_rsp_o[route_i.mst_idx].bvalid = 1'b1;
                    mst_rsp_o[route_i.mst_idx].bresp  = RESP_DECERR;
                    step_o = mst_req.bready;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/xbar_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_ctrl import axil_xbar_pkg::*; #(
    parameter int N_MST = 2
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [N_MST-1:0] wr_grant_i,
    input  logic [N_MST-1:0] rd_grant_i,
    input  route_t           wr_route_i,
    input  route_t           rd_route_i,
    input  logic             wr_step_i,
    input  logic             rd_step_i,
    output wr_state_e        wr_state_o,
    output rd_state_e        rd_state_o,
    output route_t           wr_route_o,
    output route_t           rd_route_o,
    output logic             wr_ack_o,
    output logic             rd_ack_o
);

    wr_state_e wr_state_q;
    wr_state_e wr_state_d;
    rd_state_e rd_state_q;
    rd_state_e rd_state_d;
    route_t    wr_route_q;
    route_t    rd_route_q;

    // ========================================================================
    // write path: AW, then W, then B
    // ========================================================================

    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            WR_IDLE: if (|wr_grant_i) wr_state_d = WR_ADDR;
            WR_ADDR: if (wr_step_i) wr_state_d = WR_DATA;
            WR_DATA: if (wr_step_i) wr_state_d = WR_RESP;
            WR_RESP: if (wr_step_i) wr_state_d = WR_IDLE;
            default: wr_state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_state_q <= WR_IDLE;
            wr_route_q <= '0;
        end else begin
            wr_state_q <= wr_state_d;
            if (wr_state_q == WR_IDLE && |wr_grant_i) begin
                wr_route_q <= wr_route_i;
            end
        end
    end

    // B taken by the manager, release the arbiter
    assign wr_ack_o   = (wr_state_q == WR_RESP) && wr_step_i;
    assign wr_state_o = wr_state_q;
    assign wr_route_o = wr_route_q;

    // ========================================================================
    // read path: AR, then R
    // ========================================================================

    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            RD_IDLE: if (|rd_grant_i) rd_state_d = RD_ADDR;
            RD_ADDR: if (rd_step_i) rd_state_d = RD_DATA;
            RD_DATA: if (rd_step_i) rd_state_d = RD_IDLE;
            default: rd_state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_state_q <= RD_IDLE;
            rd_route_q <= '0;
        end else begin
            rd_state_q <= rd_state_d;
            if (rd_state_q == RD_IDLE && |rd_grant_i) begin
                rd_route_q <= rd_route_i;
            end
        end
    end

    assign rd_ack_o   = (rd_state_q == RD_DATA) && rd_step_i;
    assign rd_state_o = rd_state_q;
    assign rd_route_o = rd_route_q;

endmodule

`default_nettype wire

/* logic/xbar_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_decoder import axil_xbar_pkg::*; #(
    parameter int N_MST = 2,
    parameter int N_SLV = 3,
    parameter logic [N_SLV-1:0][ADDR_WIDTH-1:0] SLV_LO = '0,
    parameter logic [N_SLV-1:0][ADDR_WIDTH-1:0] SLV_HI = '0
) (
    input  logic [N_MST-1:0]                 grant_i,
    input  logic [N_MST-1:0][ADDR_WIDTH-1:0] addr_i,
    output route_t                           route_o
);

    logic [IDX_WIDTH-1:0]  mst_idx;
    logic [ADDR_WIDTH-1:0] addr;

    // lowest set grant bit wins
    always_comb begin
        mst_idx = '0;
        for (int i = N_MST - 1; i >= 0; i--) begin
            if (grant_i[i]) begin
                mst_idx = IDX_WIDTH'(i);
            end
        end
    end

    assign addr = addr_i[mst_idx];

    // windows are inclusive, lowest subordinate wins on overlap
    always_comb begin
        route_o         = '0;
        route_o.mst_idx = mst_idx;
        for (int s = N_SLV - 1; s >= 0; s--) begin
            if (addr >= SLV_LO[s] && addr <= SLV_HI[s]) begin
                route_o.slv_idx = IDX_WIDTH'(s);
                route_o.hit     = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/xbar_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_arbiter import axil_xbar_pkg::*; #(
    parameter int N_MST = 2
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [N_MST-1:0] req_i,
    input  logic             ack_i,
    output logic [N_MST-1:0] grant_o
);

    logic [IDX_WIDTH-1:0] ptr_q;
    logic [IDX_WIDTH-1:0] next_ptr;
    logic [N_MST-1:0]     grant_rr;
    // grant held from capture until ack
    logic [N_MST-1:0]     grant_q;

    always_comb begin
        int  pos;
        logic found;
        grant_rr = '0;
        found    = 1'b0;
        for (int k = 0; k < N_MST; k++) begin
            pos = (int'(ptr_q) + k) % N_MST;
            if (!found && req_i[pos]) begin
                grant_rr[pos] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // pointer goes one past the held grant, wrapping at N_MST
    always_comb begin
        next_ptr = '0;
        for (int i = 0; i < N_MST; i++) begin
            if (grant_q[i]) begin
                next_ptr = (i == N_MST - 1) ? '0 : IDX_WIDTH'(i + 1);
            end
        end
    end

    assign grant_o = (|grant_q) ? grant_q : grant_rr;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q   <= '0;
            grant_q <= '0;
        end else if (ack_i) begin
            ptr_q   <= next_ptr;
            grant_q <= '0;
        end else if (!(|grant_q) && (|req_i)) begin
            grant_q <= grant_rr;
        end
    end

endmodule

`default_nettype wire

/* logic/axil_xbar_pkg.sv */
`default_nettype none

package axil_xbar_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // up to 16 managers and 16 subordinates
    localparam int IDX_WIDTH = 4;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_ADDR = 2'b01,
        WR_DATA = 2'b10,
        WR_RESP = 2'b11
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b10
    } rd_state_e;

    // manager side of one AXI4-Lite link
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] awaddr;
        logic [2:0]            awprot;
        logic                  awvalid;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  wvalid;
        logic                  bready;
        logic [ADDR_WIDTH-1:0] araddr;
        logic [2:0]            arprot;
        logic                  arvalid;
        logic                  rready;
    } axil_req_t;

    // subordinate side of one AXI4-Lite link
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        resp_e                 bresp;
        logic                  bvalid;
        logic                  arready;
        logic [DATA_WIDTH-1:0] rdata;
        resp_e                 rresp;
        logic                  rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic [IDX_WIDTH-1:0] mst_idx;
        logic [IDX_WIDTH-1:0] slv_idx;
        logic                 hit;
    } route_t;

endpackage

`default_nettype wire
